// ==== all.f ====
+incdir+logic
logic/tetrisPiecePkg.sv
logic/tetrisBoardPkg.sv
logic/boardRow.sv
logic/lineClearer.sv
logic/pieceDropper.sv
logic/tetrisCore.sv
tb/tetrisCore_sva.sv
tb/tetrisCoreTb.sv

// ==== logic/boardRow.sv ====
`timescale 1ns/1ps
`include "tetris_consts.svh"

module boardRow
    import tetrisBoardPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     lockEn,
    input  boardRowT lockBits,
    input  logic     shiftEn,
    input  boardRowT aboveBits,
    output boardRowT bits,
    output logic     full
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bits <= '0;
        end else if (shiftEn) begin
            bits <= aboveBits; // Row above falls into this one
        end else if (lockEn) begin
            bits <= bits | lockBits; // Merge landed piece cells
        end
    end

    assign full = &bits;

endmodule

// ==== logic/lineClearer.sv ====
`timescale 1ns/1ps
`include "tetris_consts.svh"

module lineClearer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   active,
    input  logic [`BOARD_ROWS-1:0] fullFlags,
    output logic [`BOARD_ROWS-1:0] shiftMask,
    output logic                   done,
    output logic [`LINE_CNT_W-1:0] lineCount
);

    // Scan from the floor upward. Once the lowest full row is seen, every
    // row at or above it takes the contents of the row over it.
    always_comb begin
        logic reach;
        reach = 1'b0;
        for (int i = `BOARD_ROWS-1; i >= 0; i--) begin
            reach = reach | fullFlags[i];
            shiftMask[i] = active & reach;
        end
    end

    assign done = active & ~|fullFlags; // Nothing left to clear

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lineCount <= '0;
        end else if (|shiftMask) begin
            lineCount <= lineCount + 1'b1; // One line per shift
        end
    end

endmodule

// ==== logic/pieceDropper.sv ====
`timescale 1ns/1ps
`include "tetris_consts.svh"

module pieceDropper
    import tetrisPiecePkg::*;
    import tetrisBoardPkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           spawn,
    input  pieceKindT                      spawnKind,
    input  logic [$clog2(`BOARD_COLS)-1:0] spawnCol,
    input  logic                           dropTick,
    input  logic                           lockEn,
    input  boardT                          settled,
    output boardT                          pieceRows,
    output logic                           spawnBlocked,
    output logic                           landed,
    output logic [$clog2(`BOARD_ROWS)-1:0] landRow
);

    localparam int ColW = $clog2(`BOARD_COLS);
    localparam int RowW = $clog2(`BOARD_ROWS);

    // Shape of kind drawn with its box corner at (row, col), cells below the floor dropped
    function automatic boardT placeShape(pieceKindT kind, logic [ColW-1:0] col,
                                         logic [RowW-1:0] row);
        boardT placed;
        logic [`SHAPE_BOX-1:0] cells;
        int target;
        placed = '0;
        for (int r = 0; r < `SHAPE_BOX; r++) begin
            cells = shapeRow(shapeOf(kind), r);
            target = int'(row) + r;
            if (target < `BOARD_ROWS) begin
                placed[target] = boardRowT'(cells) << col;
            end
        end
        return placed;
    endfunction

    // True when an occupied shape row would sit below row 19
    function automatic logic hitsFloor(pieceKindT kind, logic [RowW-1:0] row);
        logic hit;
        hit = 1'b0;
        for (int r = 0; r < `SHAPE_BOX; r++) begin
            if ((|shapeRow(shapeOf(kind), r)) && (int'(row) + r >= `BOARD_ROWS)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    pieceKindT       kind;
    logic [ColW-1:0] col;
    logic [RowW-1:0] row;
    logic            active;   // A piece is on the field

    logic [ColW-1:0] maxCol;
    logic [ColW-1:0] clampCol;
    logic [RowW-1:0] nextRow;
    logic [RowW-1:0] lowIdx;
    boardT           curPlaced;
    boardT           nextPlaced;
    boardT           spawnPlaced;
    logic            nextBlocked;
    logic            stepDown;

    // Keep the whole piece inside the right wall
    always_comb begin
        maxCol = ColW'(`BOARD_COLS - int'(widthOf(spawnKind)));
        clampCol = (spawnCol > maxCol) ? maxCol : spawnCol;
    end

    assign spawnPlaced  = placeShape(spawnKind, clampCol, '0);
    assign spawnBlocked = |(spawnPlaced & settled);

    assign nextRow    = row + 1'b1;
    assign curPlaced  = placeShape(kind, col, row);
    assign nextPlaced = placeShape(kind, col, nextRow);

    // Floor and settled cells both stop the piece
    assign nextBlocked = hitsFloor(kind, nextRow) | (|(nextPlaced & settled));

    assign stepDown = active & dropTick & ~nextBlocked;
    assign landed   = active & dropTick & nextBlocked;

    // Lowest occupied row inside the box
    always_comb begin
        lowIdx = '0;
        for (int r = 0; r < `SHAPE_BOX; r++) begin
            if (|shapeRow(shapeOf(kind), r)) begin
                lowIdx = RowW'(r);
            end
        end
    end

    assign landRow = row + lowIdx;

    // Also the lock mask while LOCK holds the piece still
    assign pieceRows = active ? curPlaced : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            row    <= '0;
        end else if (spawn) begin
            active <= 1'b1;
            row    <= '0; // New piece enters at the top
        end else if (lockEn) begin
            active <= 1'b0; // Cells now belong to the board
        end else if (stepDown) begin
            row <= nextRow;
        end
    end

    always_ff @(posedge clk) begin
        if (spawn) begin
            kind <= spawnKind;
            col  <= clampCol;
        end
    end

endmodule

// ==== logic/tetrisBoardPkg.sv ====
`include "tetris_consts.svh"

package tetrisBoardPkg;

    // One row of cells, bit 0 is the leftmost column
    typedef logic [`BOARD_COLS-1:0] boardRowT;

    // Whole field, index 0 is the top row
    typedef boardRowT [`BOARD_ROWS-1:0] boardT;

    typedef enum logic [2:0] {
        IDLE,  // Waiting for a piece
        FALL,  // Piece moves down on drop ticks
        LOCK,  // Piece is written into the rows
        CLEAR, // Full rows removed one per cycle
        OVER   // Spawn was blocked, held until reset
    } coreStateT;

endpackage

// ==== logic/tetrisCore.sv ====
`timescale 1ns/1ps
`include "tetris_consts.svh"

module tetrisCore
    import tetrisPiecePkg::*;
    import tetrisBoardPkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           pieceValid,
    input  pieceKindT                      pieceKind,
    input  logic [$clog2(`BOARD_COLS)-1:0] pieceCol,
    input  logic                           dropTick,
    output logic                           pieceReady,
    output logic                           busy,
    output logic                           landed,
    output logic [$clog2(`BOARD_ROWS)-1:0] landRow,
    output logic                           gameOver,
    output logic [`LINE_CNT_W-1:0]         lineCount,
    output boardT                          boardView
);

    coreStateT state;
    coreStateT stateNext;

    logic                   accept;
    logic                   spawn;
    logic                   spawnBlocked;
    logic                   fallTick;
    logic                   lockEn;
    logic                   clearActive;
    logic                   clearDone;
    boardT                  settled;
    boardT                  pieceRows;
    logic [`BOARD_ROWS-1:0] fullFlags;
    logic [`BOARD_ROWS-1:0] shiftMask;

    assign pieceReady  = (state == IDLE);
    assign busy        = (state == FALL) || (state == LOCK) || (state == CLEAR);
    assign gameOver    = (state == OVER);
    assign accept      = pieceValid & pieceReady;
    assign spawn       = accept && (pieceKind != NONE) && !spawnBlocked;
    assign fallTick    = dropTick && (state == FALL); // Ticks elsewhere are ignored
    assign lockEn      = (state == LOCK);
    assign clearActive = (state == CLEAR);

    always_comb begin
        stateNext = state;
        unique case (state)
            IDLE: begin
                if (accept && (pieceKind != NONE)) begin
                    stateNext = spawnBlocked ? OVER : FALL;
                end
            end
            FALL: begin
                if (landed) begin
                    stateNext = LOCK;
                end
            end
            LOCK: stateNext = CLEAR;
            CLEAR: begin
                if (clearDone) begin
                    stateNext = IDLE;
                end
            end
            OVER: stateNext = OVER; // Only reset leaves
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    pieceDropper uDropper (
        .clk          (clk),
        .rst          (rst),
        .spawn        (spawn),
        .spawnKind    (pieceKind),
        .spawnCol     (pieceCol),
        .dropTick     (fallTick),
        .lockEn       (lockEn),
        .settled      (settled),
        .pieceRows    (pieceRows),
        .spawnBlocked (spawnBlocked),
        .landed       (landed),
        .landRow      (landRow)
    );

    for (genvar i = 0; i < `BOARD_ROWS; i++) begin : gRow
        boardRowT above;

        // Top row refills with empty cells
        if (i == 0) begin : gTop
            assign above = '0;
        end else begin : gBody
            assign above = settled[i-1];
        end

        boardRow uRow (
            .clk       (clk),
            .rst       (rst),
            .lockEn    (lockEn),
            .lockBits  (pieceRows[i]),
            .shiftEn   (shiftMask[i]),
            .aboveBits (above),
            .bits      (settled[i]),
            .full      (fullFlags[i])
        );
    end

    lineClearer uClearer (
        .clk       (clk),
        .rst       (rst),
        .active    (clearActive),
        .fullFlags (fullFlags),
        .shiftMask (shiftMask),
        .done      (clearDone),
        .lineCount (lineCount)
    );

    assign boardView = settled | pieceRows; // Falling piece drawn over the stack

endmodule

// ==== logic/tetrisPiecePkg.sv ====
`include "tetris_consts.svh"

package tetrisPiecePkg;

    // NONE is the only illegal kind, a host uses it to offer nothing
    typedef enum logic [2:0] {
        LINE,
        SQUARE,
        ELL,
        REV_ELL,
        ESS,
        ZED,
        TEE,
        NONE
    } pieceKindT;

    // Four rows of four cells, top row in the upper nibble, bit 0 is the left column
    typedef logic [`SHAPE_BOX*`SHAPE_BOX-1:0] shapeMaskT;

    function automatic shapeMaskT shapeOf(pieceKindT kind);
        case (kind)
            LINE:    return 16'h1111; // Vertical bar
            SQUARE:  return 16'h3300;
            ELL:     return 16'h1130; // Foot points right
            REV_ELL: return 16'h2230; // Foot points left
            ESS:     return 16'h6300;
            ZED:     return 16'h3600;
            TEE:     return 16'h2700; // Stem on top
            default: return '0;
        endcase
    endfunction

    function automatic logic [$clog2(`SHAPE_BOX):0] widthOf(pieceKindT kind);
        case (kind)
            LINE:             return 1;
            SQUARE, ELL:      return 2;
            REV_ELL:          return 2;
            ESS, ZED, TEE:    return 3;
            default:          return 1;
        endcase
    endfunction

    // One row of the box, r counts down from the top
    function automatic logic [`SHAPE_BOX-1:0] shapeRow(shapeMaskT mask, int r);
        return mask[(`SHAPE_BOX-1-r)*`SHAPE_BOX +: `SHAPE_BOX];
    endfunction

endpackage

// ==== logic/tetris_consts.svh ====
`ifndef TETRIS_CONSTS_SVH
`define TETRIS_CONSTS_SVH

// Playfield size in cells
`define BOARD_ROWS 20
`define BOARD_COLS 10

// Side of the square box a piece shape is drawn in
`define SHAPE_BOX 4

// Cleared-line counter width
`define LINE_CNT_W 16

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tetrisCoreTb \
    -o simTetris > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/simTetris > sim.log 2>&1 || { cat sim.log; echo "Simulator exited with an error"; exit 1; }
cat sim.log

! grep -q "SIMULATION FAILED" sim.log || { echo "Testbench reported a failure"; exit 1; }
echo "Testbench reported no failure"

// ==== tb/tetrisCoreTb.sv ====
`timescale 1ns/1ps
`include "tetris_consts.svh"

module tetrisCoreTb
    import tetrisPiecePkg::*;
    import tetrisBoardPkg::*;
();

    localparam int RowW           = $clog2(`BOARD_ROWS);
    localparam int ColW           = $clog2(`BOARD_COLS);
    localparam int NoLanding      = 'h1f; // landRow value for a piece that never falls
    localparam int CyclesPerPiece = 60;
    localparam int ResetCycles    = 10;

    logic                   clk;
    logic                   rst;
    logic                   pieceValid;
    pieceKindT              pieceKind;
    logic [ColW-1:0]        pieceCol;
    logic                   dropTick;
    logic                   pieceReady;
    logic                   busy;
    logic                   landed;
    logic [RowW-1:0]        landRow;
    logic                   gameOver;
    logic [`LINE_CNT_W-1:0] lineCount;
    boardT                  boardView;

    // One entry per stim line
    int rstQ[$];
    int kindQ[$];
    int colQ[$];
    int rowQ[$];
    int linesQ[$];
    int bottomQ[$];
    int overQ[$];

    int   errors = 0;
    int   checks = 0;
    int   cycles = 0;
    int   limit  = 0;
    logic stimOk = 1'b1;

    tetrisCore tetrisCore_i (
        .clk        (clk),
        .rst        (rst),
        .pieceValid (pieceValid),
        .pieceKind  (pieceKind),
        .pieceCol   (pieceCol),
        .dropTick   (dropTick),
        .pieceReady (pieceReady),
        .busy       (busy),
        .landed     (landed),
        .landRow    (landRow),
        .gameOver   (gameOver),
        .lineCount  (lineCount),
        .boardView  (boardView)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Watchdog sized from the number of pieces
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, the DUT never went back to idle", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic loadStim();
        int    fd;
        int    n;
        int    f[7];
        string line;
        fd = $fopen("tb/tetris_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/tetris_stim.txt");
            stimOk = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line.substr(0, 0) == "#") begin
                    continue; // Blank or comment line
                end
                n = $sscanf(line, "%h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                if (n == 7) begin
                    rstQ.push_back(f[0]);
                    kindQ.push_back(f[1]);
                    colQ.push_back(f[2]);
                    rowQ.push_back(f[3]);
                    linesQ.push_back(f[4]);
                    bottomQ.push_back(f[5]);
                    overQ.push_back(f[6]);
                end else if (n > 0) begin
                    $display("Stim line has %0d fields instead of 7: %s", n, line);
                    stimOk = 1'b0;
                end
            end
            $fclose(fd);
            if (rstQ.size() == 0) begin
                $display("Stim file holds no pieces");
                stimOk = 1'b0;
            end
        end
    endtask

    task automatic checkRow(string name, logic [RowW-1:0] got, logic [RowW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkCount(string name, logic [`LINE_CNT_W-1:0] got,
                              logic [`LINE_CNT_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkPattern(string name, boardRowT got, boardRowT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // Empty board and idle flags right after reset
    task automatic checkAfterReset();
        checkFlag("pieceReady", pieceReady, 1'b1);
        checkFlag("busy", busy, 1'b0);
        checkFlag("landed", landed, 1'b0);
        checkFlag("gameOver", gameOver, 1'b0);
        checkCount("lineCount", lineCount, '0);
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            checkPattern($sformatf("boardView[%0d]", r), boardView[r], '0);
        end
    endtask

    task automatic playPiece(int idx);
        logic [2:0]      kindBits;
        logic            sawLanding;
        logic [RowW-1:0] gotRow;
        kindBits   = 3'(kindQ[idx]);
        sawLanding = 1'b0;
        gotRow     = '0;
        @(posedge clk);
        #1;
        while (!pieceReady) begin
            @(posedge clk);
            #1;
        end
        pieceValid = 1'b1;
        pieceKind  = pieceKindT'(kindBits);
        pieceCol   = ColW'(colQ[idx]);
        @(posedge clk); // Accepted here
        #1;
        pieceValid = 1'b0;
        dropTick   = 1'b1;
        @(negedge clk);
        while (busy && !landed) begin
            @(negedge clk);
        end
        if (landed) begin
            sawLanding = 1'b1;
            gotRow     = landRow;
        end
        @(posedge clk);
        #1;
        dropTick = 1'b0;
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk); // Flags must hold while idle

        if (rowQ[idx] == NoLanding) begin
            checkFlag("landed", sawLanding, 1'b0);
        end else begin
            checkFlag("landed", sawLanding, 1'b1);
            checkRow("landRow", gotRow, RowW'(rowQ[idx]));
        end
        checkCount("lineCount", lineCount, `LINE_CNT_W'(linesQ[idx]));
        checkPattern("boardView[19]", boardView[`BOARD_ROWS-1], boardRowT'(bottomQ[idx]));
        checkFlag("gameOver", gameOver, overQ[idx] != 0);
        checkFlag("pieceReady", pieceReady, overQ[idx] == 0);
        checkFlag("busy", busy, 1'b0);
    endtask

    initial begin
        rst        = 1'b1;
        pieceValid = 1'b0;
        pieceKind  = LINE;
        pieceCol   = '0;
        dropTick   = 1'b0;
        loadStim();
        if (!stimOk) begin
            $display("Stimulus could not be loaded, no piece was played");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            limit = rstQ.size() * CyclesPerPiece;
            repeat (ResetCycles) @(posedge clk);
            #1;
            rst = 1'b0;
            checkAfterReset();
            for (int i = 0; i < rstQ.size(); i++) begin
                if (rstQ[i] != 0) begin
                    applyReset(); // Fresh board for this sequence
                    checkAfterReset();
                end
                playPiece(i);
            end
            $display("Pieces played: %0d, checks: %0d, errors: %0d",
                     rstQ.size(), checks, errors);
            if (errors == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== tb/tetrisCore_sva.sv ====
`timescale 1ns/1ps

module tetrisCoreSva (
    input logic clk,
    input logic rst,
    input logic landed,
    input logic pieceReady,
    input logic busy,
    input logic gameOver
);

    landedPulse: assert property (
        @(posedge clk) disable iff (rst) landed |=> !landed
    ) else $error("landed was high for two cycles in a row");

    readyBusyExclusive: assert property (
        @(posedge clk) disable iff (rst) !(pieceReady && busy)
    ) else $error("pieceReady and busy were high together");

    overSticky: assert property (
        @(posedge clk) disable iff (rst) gameOver |=> gameOver
    ) else $error("gameOver fell while reset was low");

endmodule

bind tetrisCore tetrisCoreSva uSva (
    .clk        (clk),
    .rst        (rst),
    .landed     (landed),
    .pieceReady (pieceReady),
    .busy       (busy),
    .gameOver   (gameOver)
);

// ==== tb/tetris_stim.txt ====
# Each line in hex gives reset kind column landRow lineCount bottomRow gameOver
# Kinds run LINE SQUARE ELL REV_ELL ESS ZED TEE NONE from 0 and landRow 1f means no landing
1 0 4 13 0 010 0
1 1 0 13 0 003 0
1 2 2 13 0 00c 0
1 3 8 13 0 300 0
1 4 5 13 0 060 0
1 5 1 13 0 00c 0
1 6 7 13 0 380 0
1 1 0 13 0 003 0
0 1 0 11 0 003 0
0 2 0 0f 0 003 0
1 4 9 13 0 180 0
1 1 0 13 0 003 0
0 1 2 13 0 00f 0
0 1 4 13 0 03f 0
0 1 6 13 0 0ff 0
0 1 8 13 2 000 0
0 7 0 1f 2 000 0
0 0 0 13 2 001 0
0 0 0 0f 2 001 0
0 0 0 0b 2 001 0
0 0 0 07 2 001 0
0 0 0 03 2 001 0
0 0 0 1f 2 001 1
